//--- logic/mem_pipe_params.svh
`ifndef MEM_PIPE_PARAMS_SVH
`define MEM_PIPE_PARAMS_SVH

// **************************************************
// Data RAM geometry and timing
// **************************************************

`define DMEM_WORDS 256                    // Words of 32 bits
`define DMEM_AW    ($clog2(`DMEM_WORDS))  // Word index width

`define DCACHE_LAT 2                      // Load req to data_valid, at least 1

`endif

//--- logic/mem_types_pkg.sv
package mem_types_pkg;

    typedef logic [31:0] u32_t;       // Data word
    typedef logic [31:0] addr_t;      // Byte address
    typedef logic [4:0]  reg_idx_t;   // Destination register
    typedef logic [1:0]  byte_sel_t;  // Byte lane within a word

    // Load and store access size
    typedef enum logic [1:0] {
        ACC_BYTE = 2'b00,
        ACC_HALF = 2'b01,
        ACC_WORD = 2'b10
    } access_width_e;

endpackage

//--- logic/mem_stage_pkg.sv
package mem_stage_pkg;

    import mem_types_pkg::*;

    // Executed operation entering the memory back end
    typedef struct packed {
        logic          is_mem;
        logic          is_store;
        logic          is_signed;
        access_width_e width;
        u32_t          ex_out;     // ALU result, address for memory ops
        u32_t          st_data;
        logic          is_wr_rd;
        reg_idx_t      rd;
    } mem_op_t;

    typedef struct packed {
        logic          valid;
        logic          is_mem;
        logic          is_store;
        logic          is_signed;
        access_width_e width;
        byte_sel_t     byte_sel;
        u32_t          ex_out;
        logic          is_wr_rd;
        reg_idx_t      rd;
    } stage1_stage2_pass_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        logic     is_wr_rd;
        u32_t     result;      // Loaded value or ex_out
    } stage2_wb_pass_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t idx;
        u32_t     data;
    } forward_req_t;

endpackage

//--- logic/mem_stage1.sv
`timescale 1ns/100ps
`include "mem_pipe_params.svh"

module mem_stage1 (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                flush,
    input  logic                                next_rdy_in,
    input  logic                                op_valid,
    input  mem_stage_pkg::mem_op_t              op,
    output logic                                rdy_in,
    output mem_stage_pkg::stage1_stage2_pass_t  pass_out,
    output logic                                dc_req,
    output logic                                dc_we,
    output logic [`DMEM_AW-1:0]                 dc_addr,
    output logic [3:0]                          dc_be,
    output mem_types_pkg::u32_t                 dc_wdata
);

    import mem_types_pkg::*;
    import mem_stage_pkg::*;

    mem_op_t   op_r;
    logic      op_r_valid;
    logic      mem1_flush;
    logic      mem1_stall;
    logic      rdy_out;
    addr_t     addr;
    byte_sel_t byte_sel;

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            op_r_valid <= 1'b0;
        end else if (rdy_in) begin
            op_r_valid <= op_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rdy_in) begin
            op_r <= op;
        end
    end

    assign mem1_flush = flush | ~op_r_valid;
    assign mem1_stall = ~next_rdy_in;
    assign rdy_in     = mem1_flush | ~mem1_stall;
    assign rdy_out    = ~mem1_flush & ~mem1_stall;

    assign addr     = op_r.ex_out;
    assign byte_sel = (op_r.width == ACC_HALF) ? {addr[1], 1'b0} : addr[1:0];  // Bit 0 ignored

    // **************************************************
    // Data cache request
    // **************************************************

    assign dc_req   = rdy_out & op_r.is_mem;  // Once, as the op moves on
    assign dc_we    = op_r.is_store;
    assign dc_addr  = addr[`DMEM_AW+1:2];

    always_comb begin
        case (op_r.width)
            ACC_BYTE: begin
                dc_be    = 4'b0001 << byte_sel;
                dc_wdata = {4{op_r.st_data[7:0]}};
            end
            ACC_HALF: begin
                dc_be    = byte_sel[1] ? 4'b1100 : 4'b0011;
                dc_wdata = {2{op_r.st_data[15:0]}};
            end
            default: begin
                dc_be    = 4'b1111;
                dc_wdata = op_r.st_data;
            end
        endcase
    end

    // **************************************************
    // To stage 2
    // **************************************************

    assign pass_out.valid     = rdy_out;
    assign pass_out.is_mem    = op_r.is_mem;
    assign pass_out.is_store  = op_r.is_store;
    assign pass_out.is_signed = op_r.is_signed;
    assign pass_out.width     = op_r.width;
    assign pass_out.byte_sel  = byte_sel;
    assign pass_out.ex_out    = op_r.ex_out;
    assign pass_out.is_wr_rd  = op_r.is_wr_rd;
    assign pass_out.rd        = op_r.rd;

endmodule

//--- logic/dcache_ram.sv
`timescale 1ns/100ps
`include "mem_pipe_params.svh"

module dcache_ram (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 req,
    input  logic                 we,
    input  logic [`DMEM_AW-1:0]  addr,
    input  logic [3:0]           be,
    input  mem_types_pkg::u32_t  wdata,
    output mem_types_pkg::u32_t  rdata,
    output logic                 data_valid
);

    import mem_types_pkg::*;

    localparam int CNT_W = $clog2(`DCACHE_LAT + 1);

    u32_t             mem [`DMEM_WORDS];
    logic [CNT_W-1:0] lat_cnt;

    always_ff @(posedge clk) begin
        if (req) begin
            if (we) begin
                for (int i = 0; i < 4; i++) begin
                    if (be[i]) begin
                        mem[addr][8*i +: 8] <= wdata[8*i +: 8];
                    end
                end
            end else begin
                rdata <= mem[addr];  // Held until the next load
            end
        end
    end

    // Load latency counter
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            lat_cnt    <= '0;
            data_valid <= 1'b0;
        end else if (req) begin
            lat_cnt    <= we ? '0 : CNT_W'(`DCACHE_LAT - 1);
            data_valid <= ~we & (`DCACHE_LAT == 1);
        end else if (lat_cnt != '0) begin
            lat_cnt    <= lat_cnt - 1'b1;
            data_valid <= (lat_cnt == CNT_W'(1));  // Last count step
        end
    end

endmodule

//--- logic/mem_stage2.sv
`timescale 1ns/100ps

module mem_stage2 (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                flush,
    input  logic                                next_rdy_in,
    input  mem_stage_pkg::stage1_stage2_pass_t  pass_in,
    input  mem_types_pkg::u32_t                 rd_dcache_data,
    input  logic                                dcache_data_valid,
    output logic                                rdy_in,
    output mem_stage_pkg::forward_req_t         fwd_req,
    output mem_stage_pkg::stage2_wb_pass_t      pass_out
);

    import mem_types_pkg::*;
    import mem_stage_pkg::*;

    stage1_stage2_pass_t pass_in_r;
    logic                is_load;
    logic                dcache_data_stall;
    logic                mem2_flush;
    logic                mem2_stall;
    logic                rdy_out;
    logic [7:0]          mem_byte;
    logic [15:0]         mem_half;
    u32_t                mem_out;

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            pass_in_r.valid <= 1'b0;
        end else if (rdy_in) begin
            pass_in_r <= pass_in;
        end
    end

    assign is_load           = pass_in_r.is_mem & ~pass_in_r.is_store;
    assign dcache_data_stall = is_load & ~dcache_data_valid;  // Wait for load data

    assign mem2_flush = flush | ~pass_in_r.valid;
    assign mem2_stall = ~next_rdy_in | dcache_data_stall;
    assign rdy_in     = mem2_flush | ~mem2_stall;
    assign rdy_out    = ~mem2_flush & ~mem2_stall;

    // **************************************************
    // Forwarding, non-load results only
    // **************************************************

    assign fwd_req.valid = pass_in_r.is_wr_rd & ~is_load & ~mem2_flush;
    assign fwd_req.idx   = pass_in_r.rd;
    assign fwd_req.data  = pass_in_r.ex_out;

    // **************************************************
    // Load data extraction
    // **************************************************

    always_comb begin
        case (pass_in_r.byte_sel)
            2'b00:   mem_byte = rd_dcache_data[7:0];
            2'b01:   mem_byte = rd_dcache_data[15:8];
            2'b10:   mem_byte = rd_dcache_data[23:16];
            default: mem_byte = rd_dcache_data[31:24];
        endcase
    end

    assign mem_half = pass_in_r.byte_sel[1] ? rd_dcache_data[31:16] : rd_dcache_data[15:0];

    always_comb begin
        case (pass_in_r.width)
            ACC_BYTE: begin
                mem_out = {{24{pass_in_r.is_signed & mem_byte[7]}}, mem_byte};
            end
            ACC_HALF: begin
                mem_out = {{16{pass_in_r.is_signed & mem_half[15]}}, mem_half};
            end
            default: begin
                mem_out = rd_dcache_data;
            end
        endcase
    end

    assign pass_out.valid    = rdy_out;
    assign pass_out.rd       = pass_in_r.rd;
    assign pass_out.is_wr_rd = pass_in_r.is_wr_rd;
    assign pass_out.result   = is_load ? mem_out : pass_in_r.ex_out;

endmodule

//--- logic/mem_writeback.sv
`timescale 1ns/100ps

module mem_writeback (
    input  logic                            clk,
    input  logic                            rst_n,
    input  mem_stage_pkg::stage2_wb_pass_t  pass_in,
    input  logic                            retire_rdy,
    output logic                            rdy_in,
    output mem_stage_pkg::stage2_wb_pass_t  retire
);

    // Free when empty or when the held result leaves this cycle
    assign rdy_in = ~retire.valid | retire_rdy;

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            retire.valid <= 1'b0;
        end else if (rdy_in) begin
            retire <= pass_in;
        end
    end

endmodule

//--- logic/mem_pipe_top.sv
`timescale 1ns/100ps
`include "mem_pipe_params.svh"

module mem_pipe_top (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            op_valid,
    input  mem_stage_pkg::mem_op_t          op,
    input  logic                            flush,
    input  logic                            retire_rdy,
    output logic                            op_rdy,
    output mem_stage_pkg::forward_req_t     fwd_req,
    output mem_stage_pkg::stage2_wb_pass_t  retire
);

    import mem_types_pkg::*;
    import mem_stage_pkg::*;

    stage1_stage2_pass_t s1_s2_pass;
    stage2_wb_pass_t     s2_wb_pass;
    logic                s2_rdy_in;
    logic                wb_rdy_in;
    logic                dc_req;
    logic                dc_we;
    logic [`DMEM_AW-1:0] dc_addr;
    logic [3:0]          dc_be;
    u32_t                dc_wdata;
    u32_t                dc_rdata;
    logic                dc_data_valid;

    mem_stage1 mem_stage1_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .next_rdy_in (s2_rdy_in),
        .op_valid    (op_valid),
        .op          (op),
        .rdy_in      (op_rdy),
        .pass_out    (s1_s2_pass),
        .dc_req      (dc_req),
        .dc_we       (dc_we),
        .dc_addr     (dc_addr),
        .dc_be       (dc_be),
        .dc_wdata    (dc_wdata)
    );

    dcache_ram dcache_ram_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (dc_req),
        .we         (dc_we),
        .addr       (dc_addr),
        .be         (dc_be),
        .wdata      (dc_wdata),
        .rdata      (dc_rdata),
        .data_valid (dc_data_valid)
    );

    mem_stage2 mem_stage2_inst (
        .clk               (clk),
        .rst_n             (rst_n),
        .flush             (flush),
        .next_rdy_in       (wb_rdy_in),
        .pass_in           (s1_s2_pass),
        .rd_dcache_data    (dc_rdata),
        .dcache_data_valid (dc_data_valid),
        .rdy_in            (s2_rdy_in),
        .fwd_req           (fwd_req),
        .pass_out          (s2_wb_pass)
    );

    mem_writeback mem_writeback_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .pass_in    (s2_wb_pass),
        .retire_rdy (retire_rdy),
        .rdy_in     (wb_rdy_in),
        .retire     (retire)
    );

endmodule

//--- bench/mem_pipe_asserts.sv
`timescale 1ns/100ps
`include "mem_pipe_params.svh"

module mem_pipe_asserts (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            retire_rdy,
    input  logic                            dc_req,
    input  logic                            dc_we,
    input  logic                            dc_data_valid,
    input  mem_stage_pkg::stage2_wb_pass_t  retire,
    input  mem_stage_pkg::forward_req_t     fwd_req
);

    // Held result stays put until the consumer takes it
    retire_hold: assert property (@(posedge clk) disable iff (!rst_n)
        retire.valid && !retire_rdy |=> retire.valid && $stable(retire))
        else $error("Retire output changed while retire_rdy was low");

    reset_quiet: assert property (@(posedge clk)
        !rst_n |-> !retire.valid && !fwd_req.valid && !dc_req && !dc_data_valid)
        else $error("An output was active during reset");

    // Load data appears a fixed latency after a load request
    load_latency: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(dc_data_valid) |-> $past(dc_req && !dc_we, `DCACHE_LAT))
        else $error("Cache data_valid rose without a load request");

endmodule

bind mem_pipe_top mem_pipe_asserts mem_pipe_asserts_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .retire_rdy    (retire_rdy),
    .dc_req        (dc_req),
    .dc_we         (dc_we),
    .dc_data_valid (dc_data_valid),
    .retire        (retire),
    .fwd_req       (fwd_req)
);

//--- bench/mem_pipe_tb.sv
`timescale 1ns/100ps
`include "mem_pipe_params.svh"

module mem_pipe_tb;

    import mem_types_pkg::*;
    import mem_stage_pkg::*;

    localparam int MAX_LINES = 64;

    // Expected retire of one accepted op
    typedef struct packed {
        logic [2:0] grp;
        logic       is_load;
        logic       is_wr_rd;
        reg_idx_t   rd;
        u32_t       result;
    } exp_retire_t;

    logic            clk;
    logic            rst_n;
    logic            op_valid;
    mem_op_t         op;
    logic            flush;
    logic            retire_rdy;
    logic            op_rdy;
    forward_req_t    fwd_req;
    stage2_wb_pass_t retire;

    mem_op_t     stim_op    [MAX_LINES];
    u32_t        stim_exp   [MAX_LINES];
    logic [2:0]  stim_grp   [MAX_LINES];
    logic        stim_flush [MAX_LINES];
    int          stim_stall [MAX_LINES];
    int          n_lines;
    int          stall_pct;
    int          fwd_seen;
    integer      seed;
    logic        loaded;
    exp_retire_t exp_q [$];

    mem_pipe_top mem_pipe_top_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .op_valid   (op_valid),
        .op         (op),
        .flush      (flush),
        .retire_rdy (retire_rdy),
        .op_rdy     (op_rdy),
        .fwd_req    (fwd_req),
        .retire     (retire)
    );

    always #10 clk = ~clk;

    function automatic string grp_name(input logic [2:0] grp);
        case (grp)
            3'd1:    return "word_store_load";
            3'd2:    return "byte_half_lanes";
            3'd3:    return "non_mem_order";
            3'd4:    return "back_pressure";
            3'd5:    return "flush";
            default: return "unknown";
        endcase
    endfunction

    task automatic report_mismatch(input string test, input string what,
                                   input u32_t expected, input u32_t actual);
        $display("ERROR %s %s: expected %08h, actual %08h", test, what, expected, actual);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    // **************************************************
    // Output checks
    // **************************************************

    task automatic check_forward();
        int hits;
        hits = 0;
        if (fwd_req.valid) begin
            foreach (exp_q[i]) begin
                if (!exp_q[i].is_load && exp_q[i].is_wr_rd && exp_q[i].rd == fwd_req.idx
                    && exp_q[i].result == fwd_req.data) begin
                    hits++;
                end
            end
            assert (hits > 0) else abort_run($sformatf(
                "Forward request r%0d = %08h matches no op in flight", fwd_req.idx, fwd_req.data));
            fwd_seen++;
        end
    endtask

    task automatic check_retire();
        exp_retire_t e;
        assert (exp_q.size() > 0) else abort_run("A result retired with no op in flight");
        e = exp_q.pop_front();
        assert (retire.rd == e.rd)
            else report_mismatch(grp_name(e.grp), "retire rd", 32'(e.rd), 32'(retire.rd));
        assert (retire.is_wr_rd == e.is_wr_rd)
            else report_mismatch(grp_name(e.grp), "retire is_wr_rd",
                                 32'(e.is_wr_rd), 32'(retire.is_wr_rd));
        assert (retire.result == e.result)
            else report_mismatch(grp_name(e.grp), "retire result", e.result, retire.result);
    endtask

    // Drive on the falling edge and sample what the next rising edge sees
    task automatic step(input logic v, input mem_op_t o, input logic fl, output logic taken);
        @(negedge clk);
        op_valid   = v;
        op         = o;
        flush      = fl;
        retire_rdy = ($unsigned($random(seed)) % 100) >= stall_pct;
        #1;
        check_forward();
        if (retire.valid && retire_rdy) begin
            check_retire();
        end
        taken = v && op_rdy;
    endtask

    // **************************************************
    // Stimulus
    // **************************************************

    initial begin
        int               fd;
        int               cnt;
        int               li;
        logic [31:0]      g, m, s, sg, w, ex, sd, wr, rd_i, ev, fl, st;
        logic [8*128-1:0] skip_line;
        exp_retire_t      e;
        logic             taken;

        clk        = 1'b0;
        rst_n      = 1'b0;
        op_valid   = 1'b0;
        op         = '0;
        flush      = 1'b0;
        retire_rdy = 1'b0;
        seed       = 32'h1040_e8e5;
        stall_pct  = 0;
        fwd_seen   = 0;
        n_lines    = 0;
        loaded     = 1'b0;

        fd = $fopen("bench/mem_pipe_stim.txt", "r");
        assert (fd != 0) else abort_run("Cannot open the stimulus file");
        while (!$feof(fd)) begin
            cnt = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h\n",
                          g, m, s, sg, w, ex, sd, wr, rd_i, ev, fl, st);
            if (cnt == 12 && n_lines < MAX_LINES) begin
                stim_op[n_lines] = '{is_mem: m[0], is_store: s[0], is_signed: sg[0],
                                     width: access_width_e'(w[1:0]), ex_out: ex, st_data: sd,
                                     is_wr_rd: wr[0], rd: rd_i[4:0]};
                stim_exp[n_lines]   = ev;
                stim_grp[n_lines]   = g[2:0];
                stim_flush[n_lines] = fl[0];
                stim_stall[n_lines] = int'(st);
                n_lines++;
            end else begin
                cnt = $fgets(skip_line, fd);  // Comment line
            end
        end
        $fclose(fd);
        assert (n_lines > 0) else abort_run("The stimulus file holds no operations");
        loaded = 1'b1;

        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (li = 0; li < n_lines; li++) begin
            stall_pct = stim_stall[li];
            e = '{grp: stim_grp[li], is_load: stim_op[li].is_mem & ~stim_op[li].is_store,
                  is_wr_rd: stim_op[li].is_wr_rd, rd: stim_op[li].rd, result: stim_exp[li]};
            taken = 1'b0;
            if (stim_flush[li]) begin
                while (exp_q.size() > 0) begin
                    step(1'b0, '0, 1'b0, taken);  // Drain so only this op is killed
                end
                taken = 1'b0;
                while (!taken) begin
                    step(1'b1, stim_op[li], 1'b0, taken);
                end
                step(1'b0, '0, 1'b1, taken);
            end else begin
                while (!taken) begin
                    step(1'b1, stim_op[li], 1'b0, taken);
                end
                exp_q.push_back(e);
            end
        end

        while (exp_q.size() > 0) begin
            step(1'b0, '0, 1'b0, taken);
        end
        repeat (4) begin
            step(1'b0, '0, 1'b0, taken);  // Any stray retire fails here
        end
        assert (fwd_seen > 0) else abort_run("No forward request was seen during the run");
        $display("=== PASS ===");
        $finish;
    end

    // Watchdog
    initial begin
        int limit;
        wait (loaded);
        limit = n_lines * (`DCACHE_LAT + 4) * 4 + 100;
        repeat (limit) @(posedge clk);
        $display("Timeout: the ops did not all retire within %0d cycles", limit);
        $display("=== FAIL ===");
        $fatal(1);
    end

endmodule

//--- mem_pipe_top.f
+incdir+logic
logic/mem_types_pkg.sv
logic/mem_stage_pkg.sv
logic/mem_stage1.sv
logic/dcache_ram.sv
logic/mem_stage2.sv
logic/mem_writeback.sv
logic/mem_pipe_top.sv
bench/mem_pipe_asserts.sv
bench/mem_pipe_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f mem_pipe_top.f --top-module mem_pipe_tb -o mem_pipe_sim \
    && ./obj_dir/mem_pipe_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx '=== PASS ===' sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

//--- bench/mem_pipe_stim.txt
# grp mem st sgn wid ex_out st_data wr rd expected flush stall_pct  (all hex)
# wid 0 byte 1 half 2 word; stall_pct is the retire_rdy low chance in percent
1 1 1 0 2 00000100 deadbeef 0 00 00000100 0 0
1 1 0 0 2 00000100 00000000 1 05 deadbeef 0 0
1 1 1 0 2 00000104 12345678 0 00 00000104 0 0
1 1 0 0 2 00000100 00000000 1 06 deadbeef 0 0
2 1 0 1 0 00000100 00000000 1 07 ffffffef 0 0
2 1 0 0 0 00000101 00000000 1 08 000000be 0 0
2 1 0 1 0 00000102 00000000 1 09 ffffffad 0 0
2 1 0 0 0 00000103 00000000 1 0a 000000de 0 0
2 1 0 1 1 00000100 00000000 1 0b ffffbeef 0 0
2 1 0 0 1 00000103 00000000 1 0c 0000dead 0 0
2 1 1 0 0 00000105 00000055 0 00 00000105 0 0
2 1 1 0 1 00000106 0000a5c3 0 00 00000106 0 0
2 1 0 0 2 00000104 00000000 1 0d a5c35578 0 0
2 1 0 1 1 00000106 00000000 1 0f ffffa5c3 0 0
3 0 0 0 2 cafe0001 00000000 1 01 cafe0001 0 0
3 1 0 0 2 00000104 00000000 1 02 a5c35578 0 0
3 0 0 0 2 cafe0003 00000000 1 03 cafe0003 0 0
3 0 0 0 2 cafe0004 00000000 0 04 cafe0004 0 0
3 1 0 1 0 00000107 00000000 1 0e ffffffa5 0 0
3 1 0 0 0 00000104 00000000 1 10 00000078 0 0
4 1 1 0 2 00000200 0badf00d 0 00 00000200 0 28
4 0 0 0 2 00000011 00000000 1 11 00000011 0 28
4 1 0 0 2 00000200 00000000 1 12 0badf00d 0 28
4 0 0 0 2 00000013 00000000 1 13 00000013 0 32
4 1 0 1 1 00000202 00000000 1 14 00000bad 0 32
4 1 0 1 0 00000201 00000000 1 15 fffffff0 0 1e
4 0 0 0 2 00000016 00000000 1 16 00000016 0 1e
5 1 1 0 2 00000300 11111111 0 00 00000300 0 0
5 1 1 0 2 00000300 99999999 0 00 00000000 1 0
5 0 0 0 2 00000017 00000000 1 17 00000000 1 0
5 1 0 0 2 00000300 00000000 1 18 00000000 1 0
5 1 0 0 2 00000300 00000000 1 18 11111111 0 0
5 0 0 0 2 00000019 00000000 1 19 00000019 0 0
